//--- design/exu_params.svh
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`define XLEN 64

// major opcodes
`define OP        7'b0110011
`define OP_IMM    7'b0010011
`define OP_32     7'b0111011
`define OP_IMM_32 7'b0011011
`define LUI       7'b0110111

// alu operation codes, bit 4 set on the word forms
`define ALU_ADD   5'b00000
`define ALU_ADDW  5'b10000
`define ALU_SLL   5'b00001
`define ALU_SLLW  5'b10001
`define ALU_SLT   5'b00010
`define ALU_SLTU  5'b00011
`define ALU_XOR   5'b00100
`define ALU_SRL   5'b00101
`define ALU_SRLW  5'b10101
`define ALU_OR    5'b00110
`define ALU_AND   5'b00111
`define ALU_SUB   5'b01000
`define ALU_SUBW  5'b11000
`define ALU_SRA   5'b01101
`define ALU_SRAW  5'b11101
`define ALU_PASSB 5'b01111
`define ALU_MUL   5'b01001
`define ALU_MULW  5'b11001
`define ALU_DIVU  5'b01010
`define ALU_DIV   5'b01011
`define ALU_DIVUW 5'b11010
`define ALU_DIVW  5'b11011
`define ALU_REMU  5'b01100
`define ALU_REM   5'b01110
`define ALU_REMUW 5'b11100
`define ALU_REMW  5'b11110

// result selector
`define SEL_ADD   4'd0
`define SEL_AND   4'd1
`define SEL_OR    4'd2
`define SEL_XOR   4'd3
`define SEL_SHIFT 4'd4
`define SEL_PASSB 4'd5
`define SEL_CMP   4'd6
`define SEL_MUL   4'd7
`define SEL_DIV   4'd8
`define SEL_REM   4'd9

`endif

//--- design/exuPkg.sv
package exuPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [19:0] imm; // upper 20 bits of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    // one instruction word, three ways to read it
    typedef union packed {
        rTypeT r;
        iTypeT i;
        uTypeT u;
    } instrU;

    typedef logic [4:0] aluOpT;

    typedef enum logic [1:0] {
        mulLo  = 2'b00, // low half of the product
        mulHu  = 2'b01, // high, unsigned x unsigned
        mulHsu = 2'b10, // high, signed x unsigned
        mulHs  = 2'b11  // high, signed x signed
    } mulFormT;

endpackage

//--- design/aluOpDecode.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module aluOpDecode (
    input  exuPkg::instrU    instr,
    output exuPkg::aluOpT    aluOp,
    output exuPkg::mulFormT  mulForm,
    output logic             useImm,
    output logic [`XLEN-1:0] imm,
    output logic             illegal
);
    import exuPkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr.r.funct3; // same place in R and I views
    assign funct7 = instr.r.funct7; // also imm[11:5] for I view

    always_comb begin
        aluOp   = `ALU_ADD;
        mulForm = mulLo;
        useImm  = 1'b0;
        imm     = '0;
        illegal = 1'b0;
        case (instr.r.opcode)
            `OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: aluOp = `ALU_ADD;
                    {7'b0000000, 3'b001}: aluOp = `ALU_SLL;
                    {7'b0000000, 3'b010}: aluOp = `ALU_SLT;
                    {7'b0000000, 3'b011}: aluOp = `ALU_SLTU;
                    {7'b0000000, 3'b100}: aluOp = `ALU_XOR;
                    {7'b0000000, 3'b101}: aluOp = `ALU_SRL;
                    {7'b0000000, 3'b110}: aluOp = `ALU_OR;
                    {7'b0000000, 3'b111}: aluOp = `ALU_AND;
                    {7'b0100000, 3'b000}: aluOp = `ALU_SUB;
                    {7'b0100000, 3'b101}: aluOp = `ALU_SRA;
                    {7'b0000001, 3'b000}: aluOp = `ALU_MUL;
                    {7'b0000001, 3'b001}: begin
                        aluOp   = `ALU_MUL;
                        mulForm = mulHs;
                    end
                    {7'b0000001, 3'b010}: begin
                        aluOp   = `ALU_MUL;
                        mulForm = mulHsu;
                    end
                    {7'b0000001, 3'b011}: begin
                        aluOp   = `ALU_MUL;
                        mulForm = mulHu;
                    end
                    {7'b0000001, 3'b100}: aluOp = `ALU_DIV;
                    {7'b0000001, 3'b101}: aluOp = `ALU_DIVU;
                    {7'b0000001, 3'b110}: aluOp = `ALU_REM;
                    {7'b0000001, 3'b111}: aluOp = `ALU_REMU;
                    default: illegal = 1'b1;
                endcase
            end
            `OP_32: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: aluOp = `ALU_ADDW;
                    {7'b0000000, 3'b001}: aluOp = `ALU_SLLW;
                    {7'b0000000, 3'b101}: aluOp = `ALU_SRLW;
                    {7'b0100000, 3'b000}: aluOp = `ALU_SUBW;
                    {7'b0100000, 3'b101}: aluOp = `ALU_SRAW;
                    {7'b0000001, 3'b000}: aluOp = `ALU_MULW;
                    {7'b0000001, 3'b100}: aluOp = `ALU_DIVW;
                    {7'b0000001, 3'b101}: aluOp = `ALU_DIVUW;
                    {7'b0000001, 3'b110}: aluOp = `ALU_REMW;
                    {7'b0000001, 3'b111}: aluOp = `ALU_REMUW;
                    default: illegal = 1'b1;
                endcase
            end
            `OP_IMM: begin
                useImm = 1'b1;
                imm    = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
                case (funct3)
                    3'b000: aluOp = `ALU_ADD;
                    3'b010: aluOp = `ALU_SLT;
                    3'b011: aluOp = `ALU_SLTU;
                    3'b100: aluOp = `ALU_XOR;
                    3'b110: aluOp = `ALU_OR;
                    3'b111: aluOp = `ALU_AND;
                    3'b001: begin
                        aluOp   = `ALU_SLL;
                        illegal = instr.i.imm[11:6] != 6'b000000; // 6-bit shamt
                    end
                    default: begin
                        aluOp   = instr.i.imm[10] ? `ALU_SRA : `ALU_SRL;
                        illegal = {instr.i.imm[11], instr.i.imm[9:6]} != 5'b00000;
                    end
                endcase
            end
            `OP_IMM_32: begin
                useImm = 1'b1;
                imm    = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
                case ({funct7, funct3})
                    {7'b0000000, 3'b001}: aluOp = `ALU_SLLW;
                    {7'b0000000, 3'b101}: aluOp = `ALU_SRLW;
                    {7'b0100000, 3'b101}: aluOp = `ALU_SRAW;
                    default: begin
                        aluOp   = `ALU_ADDW;
                        illegal = funct3 != 3'b000; // addiw takes any imm
                    end
                endcase
            end
            `LUI: begin
                aluOp  = `ALU_PASSB;
                useImm = 1'b1;
                imm    = {{(`XLEN-32){instr.u.imm[19]}}, instr.u.imm, 12'b0};
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

//--- design/aluCtrlDecode.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module aluCtrlDecode (
    input  exuPkg::aluOpT aluOp,
    output logic          subCtl,
    output logic          signCtl,
    output logic          arithCtl,
    output logic          rightCtl,
    output logic          wordCtl,
    output logic [3:0]    resultSel
);

    // sub, sign, arith, right, word, then the selector
    logic [8:0] ctl;

    always_comb begin
        case (aluOp)
            `ALU_ADD:   ctl = {5'b00000, `SEL_ADD};
            `ALU_ADDW:  ctl = {5'b00001, `SEL_ADD};
            `ALU_SUB:   ctl = {5'b10000, `SEL_ADD};
            `ALU_SUBW:  ctl = {5'b10001, `SEL_ADD};

            `ALU_SLL:   ctl = {5'b00000, `SEL_SHIFT};
            `ALU_SLLW:  ctl = {5'b00001, `SEL_SHIFT};
            `ALU_SRL:   ctl = {5'b00010, `SEL_SHIFT};
            `ALU_SRLW:  ctl = {5'b00011, `SEL_SHIFT};
            `ALU_SRA:   ctl = {5'b00110, `SEL_SHIFT};
            `ALU_SRAW:  ctl = {5'b00111, `SEL_SHIFT};

            `ALU_SLT:   ctl = {5'b11000, `SEL_CMP}; // signed compare via sub
            `ALU_SLTU:  ctl = {5'b10000, `SEL_CMP}; // borrow
            `ALU_XOR:   ctl = {5'b00000, `SEL_XOR};
            `ALU_OR:    ctl = {5'b00000, `SEL_OR};
            `ALU_AND:   ctl = {5'b00000, `SEL_AND};
            `ALU_PASSB: ctl = {5'b00000, `SEL_PASSB};

            `ALU_MUL:   ctl = {5'b00000, `SEL_MUL};
            `ALU_MULW:  ctl = {5'b00001, `SEL_MUL};
            `ALU_DIVU:  ctl = {5'b00000, `SEL_DIV};
            `ALU_DIV:   ctl = {5'b01000, `SEL_DIV};
            `ALU_DIVUW: ctl = {5'b00001, `SEL_DIV};
            `ALU_DIVW:  ctl = {5'b01001, `SEL_DIV};
            `ALU_REMU:  ctl = {5'b00000, `SEL_REM};
            `ALU_REM:   ctl = {5'b01000, `SEL_REM};
            `ALU_REMUW: ctl = {5'b00001, `SEL_REM};
            `ALU_REMW:  ctl = {5'b01001, `SEL_REM};

            default:    ctl = {5'b00000, `SEL_ADD};
        endcase
    end

    assign {subCtl, signCtl, arithCtl, rightCtl, wordCtl, resultSel} = ctl;

endmodule

//--- design/adder64.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module adder64 (
    input  logic [`XLEN-1:0] x,
    input  logic [`XLEN-1:0] y,  // already inverted by the caller on sub
    input  logic             sub,
    output logic [`XLEN-1:0] sum,
    output logic             carry,
    output logic             sign,
    output logic             overflow,
    output logic             zero
);

    logic carryOut;

    assign {carryOut, sum} = x + y + sub; // sub doubles as carry-in

    // turned into a borrow when subtracting
    assign carry    = carryOut ^ sub;
    assign sign     = sum[`XLEN-1];
    assign overflow = (x[`XLEN-1] == y[`XLEN-1]) && (sum[`XLEN-1] != x[`XLEN-1]);
    assign zero     = sum == '0;

endmodule

//--- design/alu.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic             subCtl,
    input  logic             signCtl,
    input  logic             arithCtl,
    input  logic             rightCtl,
    input  logic             wordCtl,
    input  logic [3:0]       resultSel,
    input  exuPkg::mulFormT  mulForm,
    output logic [`XLEN-1:0] result
);
    import exuPkg::*;

    function automatic logic [`XLEN-1:0] sext32(input logic [31:0] v);
        return {{(`XLEN-32){v[31]}}, v};
    endfunction

    logic [`XLEN-1:0] adderB, sum, addRes, cmpRes;
    logic             carry, sign, overflow;
    logic [`XLEN-1:0] shiftL, shiftR, srl64, sra64;
    logic [31:0]      sllW, srlW, sraW;
    logic [`XLEN-1:0] mulRes, divRes, remRes;
    logic signed [`XLEN:0]     mulA, mulB;
    logic signed [2*`XLEN+1:0] mulProd;
    logic [`XLEN-1:0] divS, divU, remS, remU, quo64, rem64;
    logic [31:0]      divSW, divUW, remSW, remUW, quo32, rem32;
    logic             divZero, divOvf, divZeroW, divOvfW;

    assign adderB = b ^ {`XLEN{subCtl}};

    adder64 adder (
        .x        (a),
        .y        (adderB),
        .sub      (subCtl),
        .sum      (sum),
        .carry    (carry),
        .sign     (sign),
        .overflow (overflow),
        .zero     ()          // no branch unit here
    );

    assign addRes = wordCtl ? sext32(sum[31:0]) : sum;
    assign cmpRes = {{(`XLEN-1){1'b0}}, signCtl ? overflow ^ sign : carry};

    // shifts, word forms take 5-bit amounts
    assign sllW  = a[31:0] << b[4:0];
    assign srlW  = a[31:0] >> b[4:0];
    assign sraW  = $signed(a[31:0]) >>> b[4:0];
    assign srl64 = a >> b[5:0];
    assign sra64 = $signed(a) >>> b[5:0];

    assign shiftL = wordCtl ? sext32(sllW) : a << b[5:0];
    assign shiftR = wordCtl ? sext32(arithCtl ? sraW : srlW)
                            : (arithCtl ? sra64 : srl64);

    // one 65x65 signed multiplier covers all four forms
    assign mulA    = {(mulForm == mulHs || mulForm == mulHsu) & a[`XLEN-1], a};
    assign mulB    = {(mulForm == mulHs) & b[`XLEN-1], b};
    assign mulProd = mulA * mulB;

    always_comb begin
        if (mulForm != mulLo)
            mulRes = mulProd[2*`XLEN-1:`XLEN];
        else if (wordCtl)
            mulRes = sext32(mulProd[31:0]); // low word matches 32x32
        else
            mulRes = mulProd[`XLEN-1:0];
    end

    // divide/remainder, zero and overflow cases patched below
    assign divS  = $signed(a) / $signed(b);
    assign divU  = a / b;
    assign remS  = $signed(a) % $signed(b);
    assign remU  = a % b;
    assign divSW = $signed(a[31:0]) / $signed(b[31:0]);
    assign divUW = a[31:0] / b[31:0];
    assign remSW = $signed(a[31:0]) % $signed(b[31:0]);
    assign remUW = a[31:0] % b[31:0];

    assign divZero  = b == '0;
    assign divOvf   = signCtl && a == {1'b1, {(`XLEN-1){1'b0}}} && b == '1;
    assign divZeroW = b[31:0] == 32'h0;
    assign divOvfW  = signCtl && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff;

    assign quo64 = divZero ? '1 : divOvf ? a : (signCtl ? divS : divU);
    assign rem64 = divZero ? a : divOvf ? '0 : (signCtl ? remS : remU);
    assign quo32 = divZeroW ? '1 : divOvfW ? a[31:0] : (signCtl ? divSW : divUW);
    assign rem32 = divZeroW ? a[31:0] : divOvfW ? '0 : (signCtl ? remSW : remUW);

    assign divRes = wordCtl ? sext32(quo32) : quo64;
    assign remRes = wordCtl ? sext32(rem32) : rem64;

    always_comb begin
        case (resultSel)
            `SEL_ADD:   result = addRes;
            `SEL_AND:   result = a & b;
            `SEL_OR:    result = a | b;
            `SEL_XOR:   result = a ^ b;
            `SEL_SHIFT: result = rightCtl ? shiftR : shiftL;
            `SEL_PASSB: result = b;
            `SEL_CMP:   result = cmpRes;
            `SEL_MUL:   result = mulRes;
            `SEL_DIV:   result = divRes;
            default:    result = remRes;
        endcase
    end

endmodule

//--- design/exStage.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             inValid,
    output logic             inReady,
    input  logic [31:0]      instr,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    output logic             outValid,
    input  logic             outReady,
    output logic [`XLEN-1:0] result,
    output logic             illegal
);
    import exuPkg::*;

    aluOpT            aluOp;
    mulFormT          mulForm;
    logic             useImm, decIllegal;
    logic [`XLEN-1:0] imm, opB, aluResult;
    logic             subCtl, signCtl, arithCtl, rightCtl, wordCtl;
    logic [3:0]       resultSel;

    aluOpDecode opDec (
        .instr   (instr),
        .aluOp   (aluOp),
        .mulForm (mulForm),
        .useImm  (useImm),
        .imm     (imm),
        .illegal (decIllegal)
    );

    aluCtrlDecode ctlDec (
        .aluOp     (aluOp),
        .subCtl    (subCtl),
        .signCtl   (signCtl),
        .arithCtl  (arithCtl),
        .rightCtl  (rightCtl),
        .wordCtl   (wordCtl),
        .resultSel (resultSel)
    );

    assign opB = useImm ? imm : rs2Val;

    alu exAlu (
        .a         (rs1Val),
        .b         (opB),
        .subCtl    (subCtl),
        .signCtl   (signCtl),
        .arithCtl  (arithCtl),
        .rightCtl  (rightCtl),
        .wordCtl   (wordCtl),
        .resultSel (resultSel),
        .mulForm   (mulForm),
        .result    (aluResult)
    );

    // empty, or draining this edge
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (rst)
            outValid <= 1'b0;
        else if (inReady)
            outValid <= inValid;
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            result  <= decIllegal ? '0 : aluResult;
            illegal <= decIllegal;
        end
    end

    validKnown: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(outValid))
        else $error("outValid unknown");

    holdStable: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> $stable(result) && $stable(illegal))
        else $error("stalled output changed");

    // nothing enters and the held item stays
    stallBlocks: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |-> !inReady ##1 outValid)
        else $error("stalled output not held");

endmodule

//--- verif/exRefModel.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

function automatic logic [63:0] wordExt(input logic [31:0] v);
    return {{32{v[31]}}, v};
endfunction

// full 128-bit product, operands widened as the form says
function automatic logic [63:0] mulRule(input logic [63:0] x, input logic [63:0] y,
                                        input logic [2:0] f3);
    logic [127:0] xw, yw, p;
    xw = (f3 == 3'b001 || f3 == 3'b010) ? {{64{x[63]}}, x} : {64'h0, x};
    yw = (f3 == 3'b001) ? {{64{y[63]}}, y} : {64'h0, y};
    p  = xw * yw;
    return (f3 == 3'b000) ? p[63:0] : p[127:64];
endfunction

// word forms are widened first, then cut back to 32 bits
function automatic logic [63:0] divRule(input logic [63:0] x, input logic [63:0] y,
                                        input logic isSigned, input logic wantRem,
                                        input logic word);
    logic [63:0] xs, ys, q, r;
    xs = x;
    ys = y;
    if (word) begin
        xs = isSigned ? wordExt(x[31:0]) : {32'h0, x[31:0]};
        ys = isSigned ? wordExt(y[31:0]) : {32'h0, y[31:0]};
    end
    if (ys == 64'h0) begin
        q = '1;
        r = xs;
    end else if (isSigned && xs == {1'b1, 63'h0} && ys == '1) begin
        q = xs; // most negative by minus one
        r = 64'h0;
    end else if (isSigned) begin
        q = $signed(xs) / $signed(ys);
        r = $signed(xs) % $signed(ys);
    end else begin
        q = xs / ys;
        r = xs % ys;
    end
    if (wantRem)
        q = r;
    return word ? wordExt(q[31:0]) : q;
endfunction

// returns {illegal, result}
function automatic logic [64:0] refExec(input logic [31:0] ins, input logic [63:0] a,
                                        input logic [63:0] rs2);
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [63:0] b;
    logic [63:0] res;
    logic        bad;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    b   = (opc == `OP || opc == `OP_32) ? rs2 : {{52{ins[31]}}, ins[31:20]};
    res = 64'h0;
    bad = 1'b0;
    case (opc)
        `LUI: res = {{32{ins[31]}}, ins[31:12], 12'h0};
        `OP, `OP_IMM: begin
            if (opc == `OP && f7 == 7'h01) begin
                res = f3[2] ? divRule(a, b, !f3[0], f3[1], 1'b0) : mulRule(a, b, f3);
            end else begin
                if (opc == `OP)
                    bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                else
                    bad = (f3 == 3'd1 && ins[31:26] != 6'h00) ||
                          (f3 == 3'd5 && ins[31:26] != 6'h00 && ins[31:26] != 6'h10);
                case (f3)
                    3'b000: res = (opc == `OP && f7[5]) ? a - b : a + b;
                    3'b001: res = a << b[5:0];
                    3'b010: res = {63'h0, $signed(a) < $signed(b)};
                    3'b011: res = {63'h0, a < b};
                    3'b100: res = a ^ b;
                    3'b110: res = a | b;
                    3'b111: res = a & b;
                    default: begin
                        if (f7[5])
                            res = $signed(a) >>> b[5:0];
                        else
                            res = a >> b[5:0];
                    end
                endcase
            end
        end
        `OP_32, `OP_IMM_32: begin
            if (opc == `OP_32 && f7 == 7'h01) begin
                bad = f3 != 3'd0 && !f3[2];
                res = f3[2] ? divRule(a, b, !f3[0], f3[1], 1'b1) : wordExt(a[31:0] * b[31:0]);
            end else begin
                bad = !(f3 == 3'd0 && (opc == `OP_IMM_32 || f7 == 7'h00 || f7 == 7'h20)) &&
                      !(f3 == 3'd1 && f7 == 7'h00) &&
                      !(f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
                if (f3 == 3'd1)
                    res = wordExt(a[31:0] << b[4:0]);
                else if (f3 == 3'd5 && f7[5])
                    res = wordExt($signed(a[31:0]) >>> b[4:0]);
                else if (f3 == 3'd5)
                    res = wordExt(a[31:0] >> b[4:0]);
                else if (opc == `OP_32 && f7[5])
                    res = wordExt(a[31:0] - b[31:0]);
                else
                    res = wordExt(a[31:0] + b[31:0]);
            end
        end
        default: bad = 1'b1;
    endcase
    return {bad, bad ? 64'h0 : res};
endfunction

`endif

//--- verif/exStageTb.sv
`timescale 1ns/1ps
`include "exu_params.svh"

module exStageTb;
    import exuPkg::*;

    `include "exRefModel.svh"

    localparam int PERIOD = 40;
    // single items take two cycles, the stall and stream test about thirty
    localparam int CYCLES = 8 + 2 * (10 * 40 + 36 + 72 + 5 * 44 + 8 * 44 + 7) + 30;

    // {funct7, funct3} codes, first one in the low bits
    localparam logic [99:0] BASE_R = {10'h007, 10'h006, 10'h105, 10'h005, 10'h004,
                                      10'h003, 10'h002, 10'h001, 10'h100, 10'h000};
    localparam logic [49:0] WORD_R = {10'h105, 10'h005, 10'h001, 10'h100, 10'h000};
    localparam logic [383:0] EDGES = {64'h5555_5555_0000_0000, 64'h7fff_ffff_ffff_ffff,
                                      64'h0000_0001_8000_0000, 64'h8000_0000_0000_0000,
                                      64'hffff_ffff_ffff_ffff, 64'h0};

    logic             clk, rst, inValid, inReady, outValid, outReady, illegal;
    logic [31:0]      instr;
    logic [`XLEN-1:0] rs1Val, rs2Val, result;
    logic [15:0]      lfsrState;
    int               errors, checks;

    exStage DUT (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .instr    (instr),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .outValid (outValid),
        .outReady (outReady),
        .result   (result),
        .illegal  (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] randWord();
        logic [63:0] v;
        int k;
        for (k = 0; k < 64; k++)
            v = {v[62:0], nextBit()};
        return v;
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] opc, input logic [9:0] code);
        instrU w;
        w.r.funct7 = code[9:3];
        w.r.rs2    = 5'd2;
        w.r.rs1    = 5'd1;
        w.r.funct3 = code[2:0];
        w.r.rd     = 5'd3;
        w.r.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [11:0] imm12);
        instrU w;
        w       = rType(opc, {7'h00, f3});
        w.i.imm = imm12;
        return w;
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm20);
        instrU w;
        w       = rType(`LUI, 10'h000);
        w.u.imm = imm20;
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic runOne(input logic [31:0] ins, input logic [63:0] a, input logic [63:0] b);
        logic [64:0] exp;
        exp     = refExec(ins, a, b);
        instr   = ins;
        rs1Val  = a;
        rs2Val  = b;
        inValid = 1'b1;
        @(negedge clk);
        while (!inReady)
            @(negedge clk);
        @(posedge clk); // accepted here
        #2;
        inValid = 1'b0;
        @(negedge clk);
        checkValue("outValid", outValid, 1'b1);
        checkValue($sformatf("result %h", ins), result, exp[63:0]);
        checkValue($sformatf("illegal %h", ins), illegal, exp[64]);
        @(posedge clk);
        #2;
    endtask

    task automatic sweep(input logic [31:0] ins, input int nRand);
        int i, j;
        for (i = 0; i < 6; i++)
            for (j = 0; j < 6; j++)
                runOne(ins, EDGES[i*64 +: 64], EDGES[j*64 +: 64]);
        for (i = 0; i < nRand; i++)
            runOne(ins, randWord(), randWord());
    endtask

    task automatic baseOpsTest();
        logic [63:0] r;
        int k, n;
        @(negedge clk);
        checkValue("outValid", outValid, 1'b0);
        checkValue("inReady", inReady, 1'b1);
        @(posedge clk);
        #2;
        for (k = 0; k < 10; k++)
            sweep(rType(`OP, BASE_R[k*10 +: 10]), 4);
        for (n = 0; n < 4; n++) begin
            r = randWord();
            for (k = 0; k < 8; k++)
                if (k != 1 && k != 5)
                    runOne(iType(`OP_IMM, k[2:0], r[k*6 +: 12]), randWord(), randWord());
            runOne(iType(`OP_IMM, 3'd1, {6'h00, r[5:0]}), randWord(), randWord());
            runOne(iType(`OP_IMM, 3'd5, {6'h00, r[11:6]}), randWord(), randWord());
            runOne(iType(`OP_IMM, 3'd5, {6'h10, r[17:12]}), randWord(), randWord());
        end
    endtask

    task automatic wordOpsTest();
        logic [63:0] r;
        logic [9:0]  code;
        int k, n;
        for (k = 0; k < 5; k++) begin
            code = WORD_R[k*10 +: 10];
            for (n = 0; n < 8; n++) begin
                r = randWord();
                runOne(rType(`OP_32, code), randWord(), randWord());
                if (k != 1) // no subiw
                    runOne(iType(`OP_IMM_32, code[2:0],
                                 k == 0 ? r[11:0] : {code[9:3], r[4:0]}),
                           randWord(), randWord());
            end
        end
    endtask

    task automatic mulTest();
        int k;
        for (k = 0; k < 4; k++)
            sweep(rType(`OP, {7'h01, k[2:0]}), 8);
        sweep(rType(`OP_32, 10'h008), 8);
    endtask

    task automatic divTest();
        int k;
        for (k = 4; k < 8; k++) begin
            sweep(rType(`OP, {7'h01, k[2:0]}), 8);
            sweep(rType(`OP_32, {7'h01, k[2:0]}), 8);
        end
    endtask

    task automatic luiIllegalTest();
        logic [63:0] r;
        int n;
        for (n = 0; n < 4; n++) begin
            r = randWord();
            runOne(uType(r[19:0]), randWord(), randWord());
        end
        runOne(uType(20'h80001), randWord(), randWord()); // upper bit set
        runOne(rType(`OP, {7'b0000010, 3'd0}), randWord(), randWord());
        runOne(rType(`OP, {7'b1111111, 3'd5}), randWord(), randWord());
    endtask

    task automatic backPressureTest();
        logic [31:0] ins;
        logic [63:0] a1, a2, b;
        logic [64:0] exp1, exp2;
        logic [64:0] expQ [$];
        int n;
        ins      = rType(`OP, 10'h000);
        a1       = randWord();
        a2       = randWord();
        b        = randWord();
        exp1     = refExec(ins, a1, b);
        exp2     = refExec(ins, a2, b);
        outReady = 1'b0;
        instr    = ins;
        rs1Val   = a1;
        rs2Val   = b;
        inValid  = 1'b1;
        @(negedge clk);
        checkValue("inReady", inReady, 1'b1);
        @(posedge clk);
        #2;
        rs1Val = a2; // second item offered into the stall
        for (n = 0; n < 5; n++) begin
            @(negedge clk);
            checkValue("inReady", inReady, 1'b0);
            checkValue("outValid", outValid, 1'b1);
            checkValue("held result", result, exp1[63:0]);
            @(posedge clk);
            #2;
        end
        outReady = 1'b1;
        @(negedge clk);
        checkValue("inReady", inReady, 1'b1);
        @(posedge clk); // drain and refill
        #2;
        inValid = 1'b0;
        @(negedge clk);
        checkValue("outValid", outValid, 1'b1);
        checkValue("second result", result, exp2[63:0]);
        @(posedge clk);
        #2;
        @(negedge clk);
        checkValue("outValid", outValid, 1'b0);
        @(posedge clk);
        #2;
        // back to back, one result per cycle
        for (n = 0; n < 16; n++) begin
            ins     = rType(`OP, {7'h01, n[2:0]});
            a1      = randWord();
            b       = randWord();
            instr   = ins;
            rs1Val  = a1;
            rs2Val  = b;
            inValid = 1'b1;
            expQ.push_back(refExec(ins, a1, b));
            @(negedge clk);
            checkValue("inReady", inReady, 1'b1);
            if (n > 0) begin
                exp1 = expQ.pop_front();
                checkValue("outValid", outValid, 1'b1);
                checkValue("stream result", result, exp1[63:0]);
            end
            @(posedge clk);
            #2;
        end
        inValid = 1'b0;
        @(negedge clk);
        exp1 = expQ.pop_front();
        checkValue("stream result", result, exp1[63:0]);
        @(posedge clk);
        #2;
    endtask

    initial begin
        #((CYCLES + 50) * PERIOD);
        $display("run timed out before the tests finished, %0d checks, %0d errors",
                 checks, errors);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        lfsrState = 16'd55517;
        errors    = 0;
        checks    = 0;
        rst       = 1'b1;
        inValid   = 1'b0;
        outReady  = 1'b1;
        instr     = 32'h0;
        rs1Val    = '0;
        rs2Val    = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        baseOpsTest();
        wordOpsTest();
        mulTest();
        divTest();
        luiIllegalTest();
        backPressureTest();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
+incdir+verif
design/exuPkg.sv
design/aluOpDecode.sv
design/aluCtrlDecode.sv
design/adder64.sv
design/alu.sv
design/exStage.sv
verif/exStageTb.sv
